// ==== multu_unit.f ====
+incdir+include
design/multu_data_pkg.sv
design/multu_ctrl_pkg.sv
design/multu_control.sv
design/multu_datapath.sv
design/multu_top.sv
sim/tb_multu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the multu testbench with Verilator
# exits non-zero on a build error, a simulator error or a reported check failure

set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f multu_unit.f --top-module tb_multu -Mdir "$OBJ_DIR" > "$BUILD_LOG" 2>&1
status=$?
cat "$BUILD_LOG"
if [ "$status" -ne 0 ]; then
  echo "verilator build returned status $status"
  exit 1
fi

"./$OBJ_DIR/Vtb_multu" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

# the testbench prints the fail message on any mismatch or timeout
if grep -q "CHECKS FAILED" "$SIM_LOG"; then
  exit 1
fi

exit 0

// ==== sim/tb_multu.sv ====
// multu testbench: random and corner products against a behavioral multiply model
`timescale 1ns/100ps
`include "multu_macros.svh"

module tb_multu;

  localparam int NUM_RANDOM     = 200;
  localparam int NUM_CORNER     = 5;
  localparam int LATENCY        = 65;            // accepted start edge to done
  localparam int DONE_WAIT      = 2 * LATENCY;   // give up waiting for done here
  localparam int MAX_RUNS       = 220;           // products over all tests, rounded up
  localparam int CYCLES_PER_RUN = 70;            // latency plus a few idle cycles
  // about 20k cycles, 30% slack over the sum of all runs
  localparam int TIMEOUT_CYCLES = MAX_RUNS * CYCLES_PER_RUN * 13 / 10;

  // corner pairs, multiplicand x multiplier
  localparam multu_data_pkg::operand_t CORNER_A [NUM_CORNER] =
    '{32'h0000_0000, 32'h5a3c_96e1, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};
  localparam multu_data_pkg::operand_t CORNER_B [NUM_CORNER] =
    '{32'h5a3c_96e1, 32'h0000_0000, 32'h5a3c_96e1, 32'hffff_ffff, 32'h0000_0002};

  logic                          doMult;
  logic                          rst_n;
  logic                          start;
  multu_data_pkg::mul_operands_t operands;
  multu_data_pkg::product_t      product;
  logic                          busy;
  logic                          done;

  integer seed;              // $random state
  int     cycle_count = 0;   // free-running, feeds the watchdog
  int     num_checks  = 0;
  int     num_errors  = 0;

  multu_top u_multu_top
  (
    .doMult   (doMult),
    .rst_n    (rst_n),
    .start    (start),
    .operands (operands),
    .product  (product),
    .busy     (busy),
    .done     (done)
  );

  // 4 ns clock
  initial
  begin
    doMult = 1'b0;
    forever #2 doMult = ~doMult;
  end

  always @(posedge doMult) cycle_count <= cycle_count + 1;

  // watchdog, stops a hung run
  initial
  begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("run timed out after %0d cycles without reaching the end of the tests",
             cycle_count);
    $display("CHECKS FAILED");
    $finish;
  end

  // one clock; outputs are settled and inputs move 1 ns after the edge
  task automatic tick();
    @(posedge doMult);
    #1;
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    num_checks++;
    if (expected !== actual)  // catches x and z too
    begin
      num_errors++;
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // plain unsigned 64-bit product
  function automatic multu_data_pkg::product_t model_product(
    input multu_data_pkg::operand_t a, input multu_data_pkg::operand_t b);
    multu_data_pkg::product_t wide_a;
    multu_data_pkg::product_t wide_b;
    wide_a = multu_data_pkg::product_t'(a);
    wide_b = multu_data_pkg::product_t'(b);
    return wide_a * wide_b;
  endfunction

  // one-cycle start strobe, returns just after edge 0
  task automatic start_product(input multu_data_pkg::operand_t a,
                               input multu_data_pkg::operand_t b);
    operands.mcand  = a;
    operands.mplier = b;
    start           = 1'b1;
    tick();
    start = 1'b0;
  endtask

  // counts edges after edge 0 until done, optional stray start mid-run
  task automatic wait_done(input string name, input bit poke,
                           input multu_data_pkg::mul_operands_t poke_ops,
                           output int latency, output bit busy_ok);
    latency = 0;
    busy_ok = 1'b1;
    while (!done && latency < DONE_WAIT)
    begin
      if (!busy)
        busy_ok = 1'b0;
      if (poke && latency == LATENCY / 3)
      begin
        operands = poke_ops;  // different operands, must be ignored
        start    = 1'b1;
      end
      tick();
      start = 1'b0;
      latency++;
    end
    if (!busy)
      busy_ok = 1'b0;  // busy still high in the done cycle
    if (!done)
    begin
      num_errors++;
      $display("%s: done did not rise within %0d cycles of start", name, DONE_WAIT);
    end
  endtask

  // start, wait for done, compare against the model while done is high
  task automatic run_product(input string name, input multu_data_pkg::operand_t a,
                             input multu_data_pkg::operand_t b, input bit poke,
                             input multu_data_pkg::mul_operands_t poke_ops,
                             output int latency, output bit busy_ok);
    start_product(a, b);
    wait_done(name, poke, poke_ops, latency, busy_ok);
    check_value(name, model_product(a, b), product);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (num_errors == errors_before)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, num_errors - errors_before);
  endtask

  initial
  begin
    int                            errors_before;
    int                            latency;
    bit                            busy_ok;
    multu_data_pkg::operand_t      a;
    multu_data_pkg::operand_t      b;
    multu_data_pkg::mul_operands_t stray;

    rst_n    = 1'b0;
    start    = 1'b0;
    operands = '0;
    seed     = 32'h9b8b6e60;

    // reset, outputs quiet during and after
    errors_before = num_errors;
    repeat (4) tick();
    check_value("reset done", 64'(0), 64'(done));
    check_value("reset busy", 64'(0), 64'(busy));
    check_value("reset product", 64'(0), product);
    rst_n = 1'b1;
    tick();
    check_value("post reset done", 64'(0), 64'(done));
    check_value("post reset busy", 64'(0), 64'(busy));
    check_value("post reset product", 64'(0), product);
    finish_test("reset", errors_before);

    errors_before = num_errors;
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      a = $random(seed);
      b = $random(seed);
      run_product("random", a, b, 1'b0, '0, latency, busy_ok);
      tick();  // one idle cycle between runs
    end
    finish_test("random", errors_before);

    // includes the carry out of the high half for all ones
    errors_before = num_errors;
    for (int i = 0; i < NUM_CORNER; i++)
    begin
      run_product("corner", CORNER_A[i], CORNER_B[i], 1'b0, '0, latency, busy_ok);
      tick();
    end
    finish_test("corner", errors_before);

    // done exactly 65 edges after edge 0, single cycle, busy throughout
    errors_before = num_errors;
    a = $random(seed);
    b = $random(seed);
    run_product("latency", a, b, 1'b0, '0, latency, busy_ok);
    check_value("latency cycles", 64'(LATENCY), 64'(latency));
    check_value("latency busy", 64'(1), 64'(busy_ok));
    tick();
    check_value("latency done width", 64'(0), 64'(done));
    check_value("latency idle busy", 64'(0), 64'(busy));
    finish_test("latency", errors_before);

    // stray start mid-run leaves the first product alone
    errors_before = num_errors;
    a            = $random(seed);
    b            = $random(seed);
    stray.mcand  = ~a;
    stray.mplier = b ^ 32'h0f0f_0f0f;
    run_product("start while busy", a, b, 1'b1, stray, latency, busy_ok);
    check_value("start while busy cycles", 64'(LATENCY), 64'(latency));
    check_value("start while busy busy", 64'(1), 64'(busy_ok));
    tick();
    check_value("start while busy idle", 64'(0), 64'(busy));
    finish_test("start while busy", errors_before);

    // second start lands in the done cycle of the first
    errors_before = num_errors;
    a = $random(seed);
    b = $random(seed);
    run_product("back to back first", a, b, 1'b0, '0, latency, busy_ok);
    a = $random(seed);
    b = $random(seed);
    run_product("back to back second", a, b, 1'b0, '0, latency, busy_ok);
    check_value("back to back cycles", 64'(LATENCY), 64'(latency));
    check_value("back to back busy", 64'(1), 64'(busy_ok));
    tick();
    finish_test("back to back", errors_before);

    $display("checks %0d, errors %0d, cycles %0d", num_checks, num_errors, cycle_count);
    if (num_errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== design/multu_top.sv ====
// multu top: sequential unsigned 32x32 shift-add multiplier
`timescale 1ns/100ps

module multu_top
(
  input  logic                          doMult,    // clock
  input  logic                          rst_n,     // async, active low
  input  logic                          start,     // single-cycle strobe, ignored while busy
  input  multu_data_pkg::mul_operands_t operands,  // sampled with start
  output multu_data_pkg::product_t      product,   // valid from done to next start
  output logic                          busy,      // product in flight
  output logic                          done       // one-cycle pulse, 65 cycles after start
);

  multu_ctrl_pkg::mul_step_t step;      // control to datapath command
  logic                      prod_lsb;  // datapath back to control

  // sequencer
  multu_control u_control
  (
    .doMult   (doMult),
    .rst_n    (rst_n),
    .start    (start),
    .prod_lsb (prod_lsb),
    .step     (step),
    .busy     (busy),
    .done     (done)
  );

  // product register and adder
  multu_datapath u_datapath
  (
    .doMult   (doMult),
    .rst_n    (rst_n),
    .step     (step),
    .operands (operands),
    .product  (product),
    .prod_lsb (prod_lsb)
  );

endmodule

// ==== design/multu_datapath.sv ====
// multu datapath: 65-bit product register with conditional adder and right shifter
`timescale 1ns/100ps
`include "multu_macros.svh"

module multu_datapath
(
  input  logic                          doMult,    // clock
  input  logic                          rst_n,     // async, active low
  input  multu_ctrl_pkg::mul_step_t     step,      // command from control
  input  multu_data_pkg::mul_operands_t operands,  // sampled on load
  output multu_data_pkg::product_t      product,   // lower 64 bits of the register
  output logic                          prod_lsb   // decides the next add
);

  // product register layout
  //   [64]    carry out of the high-half add
  //   [63:32] high half, accumulates the multiplicand
  //   [31:0]  low half, starts as the multiplier
  logic [2*`MULTU_WIDTH:0]  prod_q;
  multu_data_pkg::operand_t mcand_q;  // multiplicand held for the whole run
  multu_data_pkg::operand_t addend;   // multiplicand or zero
  logic [`MULTU_WIDTH:0]    hi_sum;   // high half plus addend, with carry

  // multiplicand when the product lsb was set, else zero
  assign addend = step.add_mcand ? mcand_q : '0;

  // 33-bit sum, carry lands in bit 64
  assign hi_sum = {1'b0, prod_q[2*`MULTU_WIDTH-1:`MULTU_WIDTH]} + {1'b0, addend};

  // multiplicand capture
  always_ff @(posedge doMult)
  begin
    if (step.load)
    begin
      mcand_q <= operands.mcand;
    end
  end

  // product register, one command per cycle
  always_ff @(posedge doMult or negedge rst_n)
  begin
    if (!rst_n)
    begin
      prod_q <= '0;
    end
    else if (step.load)
    begin
      // clear carry and high half, multiplier into low half
      prod_q <= {{(`MULTU_WIDTH+1){1'b0}}, operands.mplier};
    end
    else if (step.add_step)
    begin
      prod_q[2*`MULTU_WIDTH:`MULTU_WIDTH] <= hi_sum;  // low half untouched
    end
    else if (step.shift)
    begin
      prod_q <= {1'b0, prod_q[2*`MULTU_WIDTH:1]};  // carry moves into bit 63
    end
  end

  // outputs straight off the register
  assign product  = prod_q[2*`MULTU_WIDTH-1:0];
  assign prod_lsb = prod_q[0];

  // control never issues two commands at once
  a_one_cmd: assert property (@(posedge doMult) disable iff (!rst_n)
    $onehot0({step.load, step.add_step, step.shift}));

  // the preceding shift or load leaves the carry bit clear for each add
  a_carry_clear: assert property (@(posedge doMult) disable iff (!rst_n)
    step.add_step |-> !prod_q[2*`MULTU_WIDTH]);

endmodule

// ==== design/multu_control.sv ====
// multu control: alternates add and shift steps, counts shifts, pulses done
`timescale 1ns/100ps
`include "multu_macros.svh"

module multu_control
(
  input  logic                      doMult,    // clock
  input  logic                      rst_n,     // async, active low
  input  logic                      start,     // single-cycle start strobe
  input  logic                      prod_lsb,  // bit 0 of the product register
  output multu_ctrl_pkg::mul_step_t step,      // command to the datapath
  output logic                      busy,      // product in flight
  output logic                      done       // one-cycle completion pulse
);

  multu_ctrl_pkg::ctrl_state_e  state_q;
  multu_ctrl_pkg::ctrl_state_e  state_d;
  multu_ctrl_pkg::shift_count_t count_q;  // shifts taken so far
  multu_ctrl_pkg::shift_count_t count_d;

  // next state, next count and the step command
  always_comb
  begin
    state_d = state_q;
    count_d = count_q;
    step    = '0;  // no command by default
    case (state_q)
      multu_ctrl_pkg::IDLE:
      begin
        if (start)
        begin
          step.load = 1'b1;  // datapath samples operands on this edge
          count_d   = '0;
          state_d   = multu_ctrl_pkg::ADD;
        end
      end
      multu_ctrl_pkg::ADD:
      begin
        step.add_step  = 1'b1;
        step.add_mcand = prod_lsb;  // lsb set means add multiplicand
        state_d        = multu_ctrl_pkg::SHIFT;
      end
      multu_ctrl_pkg::SHIFT:
      begin
        step.shift = 1'b1;
        count_d    = count_q + multu_ctrl_pkg::shift_count_t'(1);
        // count after this shift, msb set on shift number 32
        if (count_d[`MULTU_CNT_W-1])
        begin
          state_d = multu_ctrl_pkg::FINISH;
        end
        else
        begin
          state_d = multu_ctrl_pkg::ADD;  // next bit
        end
      end
      multu_ctrl_pkg::FINISH:
      begin
        state_d = multu_ctrl_pkg::IDLE;  // done goes high next cycle
      end
      default:
      begin
        state_d = multu_ctrl_pkg::IDLE;
      end
    endcase
  end

  // state and shift counter
  always_ff @(posedge doMult or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= multu_ctrl_pkg::IDLE;
      count_q <= '0;
    end
    else
    begin
      state_q <= state_d;
      count_q <= count_d;
    end
  end

  // done is registered off FINISH so it lands in the idle cycle
  // a start in that same cycle is accepted
  always_ff @(posedge doMult or negedge rst_n)
  begin
    if (!rst_n)
    begin
      done <= 1'b0;
    end
    else
    begin
      done <= (state_q == multu_ctrl_pkg::FINISH);
    end
  end

  // busy from the first add through the done cycle
  assign busy = (state_q != multu_ctrl_pkg::IDLE) | done;

  // done never stretches, even with a back-to-back start
  a_done_single: assert property (@(posedge doMult) disable iff (!rst_n)
    done |=> !done);

  // every add is followed by its shift
  a_shift_after_add: assert property (@(posedge doMult) disable iff (!rst_n)
    (state_q == multu_ctrl_pkg::ADD) |=> (state_q == multu_ctrl_pkg::SHIFT));

  // the counter stops at 32 shifts
  a_count_bound: assert property (@(posedge doMult) disable iff (!rst_n)
    (state_q != multu_ctrl_pkg::FINISH) |-> (count_q <= `MULTU_SHIFTS));

endmodule

// ==== design/multu_ctrl_pkg.sv ====
// multu control types for the sequencer state, shift count and step command
`include "multu_macros.svh"

package multu_ctrl_pkg;

  // shift step counter, msb marks the last shift
  typedef logic [`MULTU_CNT_W-1:0] shift_count_t;

  // sequencer states
  typedef enum logic [1:0]
  {
    IDLE   = 2'd0,  // waiting for start
    ADD    = 2'd1,  // conditional add into the high half
    SHIFT  = 2'd2,  // right shift of the product register
    FINISH = 2'd3   // last shift done, done pulse follows
  } ctrl_state_e;

  // command from control to datapath, at most one of load/add_step/shift
  typedef struct packed
  {
    logic load;       // capture new operands
    logic add_step;   // add step this cycle
    logic add_mcand;  // add multiplicand, else add zero
    logic shift;      // shift right by one
  } mul_step_t;

endpackage

// ==== design/multu_data_pkg.sv ====
// multu data types for operands, product and the operand bundle
`include "multu_macros.svh"

package multu_data_pkg;

  // one operand word
  typedef logic [`MULTU_WIDTH-1:0] operand_t;

  // full unsigned product, two words
  typedef logic [2*`MULTU_WIDTH-1:0] product_t;

  // operands sampled together with start
  typedef struct packed
  {
    operand_t mcand;   // multiplicand, added into the high half
    operand_t mplier;  // multiplier, loaded into the low half
  } mul_operands_t;

endpackage

// ==== include/multu_macros.svh ====
// multu width and step-count macros shared by the packages and the datapath
`ifndef MULTU_MACROS_SVH
`define MULTU_MACROS_SVH

// operand width in bits, one word per operand
`define MULTU_WIDTH 32

// shift counter width
// top bit sets after MULTU_SHIFTS shift steps
`define MULTU_CNT_W 6

// number of shift steps per product, one per multiplier bit
`define MULTU_SHIFTS 32

`endif
